// ==== verilog.f ====
+incdir+testbench
logic/rv_isa_pkg.sv
logic/id_uop_pkg.sv
logic/id_pipe_reg.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
testbench/id_stage_tb.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - logic/rv_isa_pkg.sv
  - logic/id_uop_pkg.sv
  - logic/id_pipe_reg.sv
  - logic/inst_decoder.sv
  - logic/gpr_file.sv
  - logic/operand_bypass.sv
  - logic/branch_unit.sv
  - logic/id_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/id_stage_tb.sv

// ==== testbench/id_ref_model.svh ====
// body-level include for the testbench module, which must import rv_isa_pkg and id_uop_pkg
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

typedef struct packed {
  logic [XLEN-1:0] imm;
  alu_op_e         alu_op;
  src1_sel_e       src1;
  src2_sel_e       src2;
  logic            gpr_wen;
  logic            mem_ren;
  logic            mem_wen;
  logic            load_sel;
  logic            invalid;
  br_kind_e        kind;
} dec_t;

logic [XLEN-1:0] model_regs [NUM_GPR];  // entry 0 unused, x0 reads zero

function automatic alu_op_e alu_of_funct3(input logic [2:0] f3);
  case (f3)
    3'd0:    return ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

function automatic dec_t decode_word(input logic [INST_WD-1:0] w);
  dec_t            d;
  logic [6:0]      opc;
  logic [2:0]      f3;
  logic [5:0]      top6;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  opc   = w[6:0];
  f3    = w[14:12];
  top6  = w[31:26];
  imm_i = XLEN'($signed(w[31:20]));
  imm_s = XLEN'($signed({w[31:25], w[11:7]}));
  imm_b = XLEN'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
  imm_u = XLEN'($signed({w[31:12], 12'h000}));
  imm_j = XLEN'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
  d = '0;
  d.gpr_wen  = opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP};
  d.mem_ren  = opc == OPC_LOAD;
  d.load_sel = opc == OPC_LOAD;
  d.mem_wen  = opc == OPC_STORE;
  d.src1     = (opc inside {OPC_AUIPC, OPC_JAL, OPC_JALR}) ? SRC1_PC : SRC1_RS1;
  if (opc inside {OPC_JAL, OPC_JALR}) d.src2 = SRC2_FOUR;  // link value pc + 4
  else if (opc inside {OPC_OP, OPC_BRANCH}) d.src2 = SRC2_RS2;
  else d.src2 = SRC2_IMM;
  case (opc)
    OPC_LUI, OPC_AUIPC: d.imm = imm_u;
    OPC_JAL:            d.imm = imm_j;
    OPC_BRANCH:         d.imm = imm_b;
    OPC_STORE:          d.imm = imm_s;
    OPC_OP:             d.imm = '0;
    default:            d.imm = imm_i;
  endcase
  if (opc == OPC_LUI) d.alu_op = ALU_PASS_B;
  if (opc inside {OPC_OP_IMM, OPC_OP}) begin
    d.alu_op = alu_of_funct3(f3);
    if (w[30] && f3 == 3'd5) d.alu_op = ALU_SRA;
    if (w[30] && f3 == 3'd0 && opc == OPC_OP) d.alu_op = ALU_SUB;
  end
  if (opc == OPC_BRANCH) d.kind = BR_COND;
  if (opc == OPC_JAL) d.kind = BR_JAL;
  if (opc == OPC_JALR) d.kind = BR_JALR;
  case (opc)
    OPC_LUI, OPC_AUIPC, OPC_JAL: d.invalid = 1'b0;
    OPC_JALR:   d.invalid = f3 != 3'd0;
    OPC_BRANCH: d.invalid = f3 inside {3'd2, 3'd3};
    OPC_LOAD:   d.invalid = f3 != F3_LD;
    OPC_STORE:  d.invalid = f3 != F3_SD;
    OPC_OP_IMM: d.invalid = (f3 == 3'd1 && top6 != 6'd0) ||
                            (f3 == 3'd5 && !(top6 inside {6'b000000, 6'b010000}));
    OPC_OP:     d.invalid = !(w[31:25] == 7'd0 || (w[31:25] == 7'b0100000 && f3 inside {3'd0, 3'd5}));
    default:    d.invalid = 1'b1;
  endcase
  if (d.invalid) begin
    d.gpr_wen  = 1'b0;
    d.mem_ren  = 1'b0;
    d.mem_wen  = 1'b0;
    d.load_sel = 1'b0;
    d.kind     = BR_NONE;
  end
  return d;
endfunction

// later stages override earlier, so execute ends up on top
function automatic logic [XLEN-1:0] forward_operand(
    input logic [GPR_ADDR_WD-1:0] rs,
    input logic [GPR_ADDR_WD-1:0] es_rd, input logic [XLEN-1:0] es_res,
    input logic [GPR_ADDR_WD-1:0] ms_rd, input logic [XLEN-1:0] ms_res,
    input logic [GPR_ADDR_WD-1:0] ws_rd, input logic [XLEN-1:0] ws_res);
  logic [XLEN-1:0] v;
  v = (rs == '0) ? '0 : model_regs[rs];
  if (rs != '0 && ws_rd == rs) v = ws_res;
  if (rs != '0 && ms_rd == rs) v = ms_res;
  if (rs != '0 && es_rd == rs) v = es_res;
  return v;
endfunction

function automatic logic resolve_branch(input dec_t d, input logic [2:0] f3,
                                        input logic [XLEN-1:0] a, b, pc,
                                        output logic [XLEN-1:0] tgt);
  tgt = (d.kind == BR_JALR) ? ((a + d.imm) & ~XLEN'(1)) : pc + d.imm;
  if (d.kind == BR_JAL || d.kind == BR_JALR) return 1'b1;
  if (d.kind != BR_COND) return 1'b0;
  case (f3)
    F3_BEQ:  return a == b;
    F3_BNE:  return a != b;
    F3_BLT:  return $signed(a) < $signed(b);
    F3_BGE:  return $signed(a) >= $signed(b);
    F3_BLTU: return a < b;
    F3_BGEU: return a >= b;
    default: return 1'b0;
  endcase
endfunction

`endif

// ==== testbench/id_stage_tb.sv ====
// single instruction offered at a time; every cycle is checked against the reference model
`timescale 1ns/1ps

module id_stage_tb import rv_isa_pkg::*, id_uop_pkg::*; ();

  localparam int unsigned SEED    = 32'hb789;
  localparam int NUM_INSTS        = 2000;
  localparam int RESET_CYCLES     = 16;
  localparam int ACCEPT_TIMEOUT   = 64;
  localparam int DRAIN_TIMEOUT    = 64;

  logic                   i_clk = 1'b0;
  logic                   i_rst;
  logic                   i_fs_to_ds_valid;
  logic [INST_WD-1:0]     i_fs_inst;
  logic [XLEN-1:0]        i_fs_pc;
  logic                   o_ds_allowin;
  logic                   i_es_allowin;
  logic                   o_ds_to_es_valid;
  logic [XLEN-1:0]        o_rs1_data, o_rs2_data, o_imm, o_pc;
  alu_op_e                o_alu_op;
  src1_sel_e              o_src1_sel;
  src2_sel_e              o_src2_sel;
  logic [GPR_ADDR_WD-1:0] o_rd;
  logic                   o_gpr_wen, o_mem_ren, o_mem_wen, o_load_sel, o_invalid_inst;
  logic [GPR_ADDR_WD-1:0] i_es_rd, i_ms_rd, i_ws_rd;
  logic [XLEN-1:0]        i_es_result, i_ms_result, i_ws_result;
  logic                   i_es_load_sel;
  logic                   i_rf_wen;
  logic [GPR_ADDR_WD-1:0] i_rf_waddr;
  logic [XLEN-1:0]        i_rf_wdata;
  logic                   o_br_sel, o_br_taken;
  logic [XLEN-1:0]        o_br_target;

  logic               stage_valid;  // model of the stage valid bit
  logic [INST_WD-1:0] cur_inst;
  logic [XLEN-1:0]    cur_pc;

  `include "id_ref_model.svh"

  id_stage UUT (.*);

  always #10 i_clk = ~i_clk;

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // biased toward the registers the current instruction reads
  function automatic logic [GPR_ADDR_WD-1:0] pick_rd(input logic [GPR_ADDR_WD-1:0] rs1, rs2);
    case ($urandom_range(0, 3))
      0:       return '0;
      1:       return rs1;
      2:       return rs2;
      default: return GPR_ADDR_WD'($urandom);
    endcase
  endfunction

  function automatic logic [INST_WD-1:0] rand_inst();
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3, bf3;
    r   = $urandom;
    rd  = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    f3  = 3'($urandom);
    bf3 = (f3 inside {3'd2, 3'd3}) ? f3 + 3'd2 : f3;  // skip reserved branch codes
    case ($urandom_range(0, 11))
      0:  return {r[31:12], rd, OPC_LUI};
      1:  return {r[31:12], rd, OPC_AUIPC};
      2:  return {r[31:12], rd, OPC_JAL};
      3:  return {r[31:20], rs1, 3'b000, rd, OPC_JALR};
      4, 5: return {r[31:25], rs2, rs1, bf3, r[11:7], OPC_BRANCH};
      6:  return {r[31:20], rs1, F3_LD, rd, OPC_LOAD};
      7:  return {r[31:25], rs2, rs1, F3_SD, r[11:7], OPC_STORE};
      8: begin
        if (f3 == 3'd1) return {6'b000000, r[25:20], rs1, f3, rd, OPC_OP_IMM};
        if (f3 == 3'd5) return {r[30] ? 6'b010000 : 6'b000000, r[25:20], rs1, f3, rd, OPC_OP_IMM};
        return {r[31:20], rs1, f3, rd, OPC_OP_IMM};
      end
      9:  return {(r[30] && f3 inside {3'd0, 3'd5}) ? 7'b0100000 : 7'b0000000,
                  rs2, rs1, f3, rd, OPC_OP};
      10: return r[0] ? {r[31:7], 7'b1110011} : {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
      default: return {r[31:20], rs1, 3'b010, rd, OPC_LOAD};  // lw is not in the subset
    endcase
  endfunction

  // entered 2 ns after a rising edge, returns 2 ns after the next one
  task automatic run_cycle(output logic accepted);
    dec_t                   d;
    logic [GPR_ADDR_WD-1:0] rs1, rs2;
    logic [XLEN-1:0]        a, b, tgt;
    logic                   hazard, go, allowin, sel, taken;
    rs1           = cur_inst[19:15];
    rs2           = cur_inst[24:20];
    i_es_rd       = pick_rd(rs1, rs2);
    i_ms_rd       = pick_rd(rs1, rs2);
    i_ws_rd       = pick_rd(rs1, rs2);
    i_es_result   = {$urandom, $urandom};
    i_ms_result   = {$urandom, $urandom};
    i_ws_result   = {$urandom, $urandom};
    i_es_load_sel = $urandom_range(0, 3) == 0;
    i_es_allowin  = $urandom_range(0, 3) != 0;
    i_rf_wen      = $urandom_range(0, 3) == 0;
    i_rf_waddr    = GPR_ADDR_WD'($urandom);
    i_rf_wdata    = {$urandom, $urandom};
    @(negedge i_clk);
    hazard  = i_es_load_sel && i_es_rd != '0 && (i_es_rd == rs1 || i_es_rd == rs2);
    go      = stage_valid && !hazard;
    allowin = !stage_valid || (!hazard && i_es_allowin);
    d = decode_word(cur_inst);
    a = forward_operand(rs1, i_es_rd, i_es_result, i_ms_rd, i_ms_result, i_ws_rd, i_ws_result);
    b = forward_operand(rs2, i_es_rd, i_es_result, i_ms_rd, i_ms_result, i_ws_rd, i_ws_result);
    sel   = go && resolve_branch(d, cur_inst[14:12], a, b, cur_pc, tgt);
    taken = sel && (tgt != i_fs_pc);
    check_value("o_ds_to_es_valid", o_ds_to_es_valid, go);
    check_value("o_ds_allowin", o_ds_allowin, allowin);
    check_value("o_br_sel", o_br_sel, sel);
    check_value("o_br_taken", o_br_taken, taken);
    if (sel) check_value("o_br_target", o_br_target, tgt);
    if (stage_valid) begin
      check_value("o_pc", o_pc, cur_pc);
      check_value("o_rd", o_rd, cur_inst[11:7]);
      check_value("o_rs1_data", o_rs1_data, a);
      check_value("o_rs2_data", o_rs2_data, b);
      check_value("o_invalid_inst", o_invalid_inst, d.invalid);
      check_value("o_gpr_wen", o_gpr_wen, d.gpr_wen);
      check_value("o_mem_ren", o_mem_ren, d.mem_ren);
      check_value("o_mem_wen", o_mem_wen, d.mem_wen);
      check_value("o_load_sel", o_load_sel, d.load_sel);
      if (!d.invalid) begin
        check_value("o_imm", o_imm, d.imm);
        check_value("o_alu_op", o_alu_op, d.alu_op);
        check_value("o_src1_sel", o_src1_sel, d.src1);
        check_value("o_src2_sel", o_src2_sel, d.src2);
      end
    end
    accepted = i_fs_to_ds_valid && allowin;
    @(posedge i_clk);
    if (i_rf_wen && i_rf_waddr != '0) model_regs[i_rf_waddr] = i_rf_wdata;
    if (allowin) stage_valid = i_fs_to_ds_valid;
    if (accepted) begin
      cur_inst = taken ? INST_NOP : i_fs_inst;  // wrong path squashed
      cur_pc   = i_fs_pc;
    end
    #2;
  endtask

  task automatic load_registers();
    for (int r = 0; r < NUM_GPR; r++) begin
      i_rf_wen   = 1'b1;
      i_rf_waddr = GPR_ADDR_WD'(r);
      i_rf_wdata = {$urandom, $urandom};
      @(posedge i_clk);
      if (r != 0) model_regs[r] = i_rf_wdata;
      #2;
    end
    i_rf_wen = 1'b0;
  endtask

  task automatic offer(input logic [INST_WD-1:0] w);
    dec_t d;
    logic acc;
    int   waited;
    d                = decode_word(cur_inst);
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst        = w;
    // sometimes fetch already sits on the target, so no flush
    i_fs_pc = ($urandom_range(0, 3) == 0) ? cur_pc + d.imm : {$urandom, $urandom} & ~XLEN'(3);
    acc    = 1'b0;
    waited = 0;
    while (!acc) begin
      if (waited == ACCEPT_TIMEOUT) timeout_fail("decode stage never accepted the instruction");
      run_cycle(acc);
      waited++;
    end
    i_fs_to_ds_valid = 1'b0;
  endtask

  initial begin
    int unsigned seed_sink;
    logic        acc;
    int          waited;
    seed_sink        = $urandom(SEED);
    i_rst            = 1'b1;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = INST_NOP;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    i_es_result      = '0;
    i_ms_result      = '0;
    i_ws_result      = '0;
    i_es_load_sel    = 1'b0;
    i_rf_wen         = 1'b0;
    i_rf_waddr       = '0;
    i_rf_wdata       = '0;
    stage_valid      = 1'b0;
    cur_inst         = INST_NOP;
    cur_pc           = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #2 i_rst = 1'b0;
    @(negedge i_clk);
    check_value("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    check_value("o_br_sel", o_br_sel, 1'b0);
    check_value("o_br_taken", o_br_taken, 1'b0);
    check_value("o_ds_allowin", o_ds_allowin, 1'b1);
    @(posedge i_clk);
    #2;
    load_registers();
    for (int n = 0; n < NUM_INSTS; n++) begin
      if ($urandom_range(0, 7) == 0) run_cycle(acc);  // fetch bubble
      offer(rand_inst());
    end
    waited = 0;
    while (stage_valid) begin
      if (waited == DRAIN_TIMEOUT) timeout_fail("last instruction never left the decode stage");
      run_cycle(acc);
      waited++;
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== logic/id_stage.sv ====
// decode stage of a 5-stage RV64I pipe; no CSR, traps or word ops, payload valid only with valid
`timescale 1ns/1ps

module id_stage import rv_isa_pkg::*, id_uop_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  // fetch
  input  logic                   i_fs_to_ds_valid,
  input  logic [INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]        i_fs_pc,
  output logic                   o_ds_allowin,
  // execute
  input  logic                   i_es_allowin,
  output logic                   o_ds_to_es_valid,
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data,
  output logic [XLEN-1:0]        o_imm,
  output logic [XLEN-1:0]        o_pc,
  output alu_op_e                o_alu_op,
  output src1_sel_e              o_src1_sel,
  output src2_sel_e              o_src2_sel,
  output logic [GPR_ADDR_WD-1:0] o_rd,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output logic                   o_load_sel,
  output logic                   o_invalid_inst,
  // forwarding
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]        i_es_result,
  input  logic                   i_es_load_sel,
  input  logic [GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]        i_ms_result,
  input  logic [GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [XLEN-1:0]        i_ws_result,
  // register write from writeback
  input  logic                   i_rf_wen,
  input  logic [GPR_ADDR_WD-1:0] i_rf_waddr,
  input  logic [XLEN-1:0]        i_rf_wdata,
  // redirect
  output logic                   o_br_sel,
  output logic                   o_br_taken,
  output logic [XLEN-1:0]        o_br_target
);

  logic [INST_WD-1:0]     ds_inst;
  logic [GPR_ADDR_WD-1:0] rs1;
  logic [GPR_ADDR_WD-1:0] rs2;
  logic [XLEN-1:0]        rf_rdata1;
  logic [XLEN-1:0]        rf_rdata2;
  logic                   load_hazard;
  br_kind_e               br_kind;
  logic [F3_WD-1:0]       br_funct3;

  id_pipe_reg u_pipe_reg (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_load_hazard    (load_hazard),
    .i_br_taken       (o_br_taken),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_pc)
  );

  inst_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_src1_sel     (o_src1_sel),
    .o_src2_sel     (o_src2_sel),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_load_sel     (o_load_sel),
    .o_br_kind      (br_kind),
    .o_br_funct3    (br_funct3),
    .o_invalid_inst (o_invalid_inst)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rf_rdata1),
    .i_raddr2 (rs2),
    .o_rdata2 (rf_rdata2),
    .i_wen    (i_rf_wen),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata)
  );

  operand_bypass u_bypass (
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es_rd       (i_es_rd),
    .i_es_result   (i_es_result),
    .i_es_load_sel (i_es_load_sel),
    .i_ms_rd       (i_ms_rd),
    .i_ms_result   (i_ms_result),
    .i_ws_rd       (i_ws_rd),
    .i_ws_result   (i_ws_result),
    .o_rs1_data    (o_rs1_data),
    .o_rs2_data    (o_rs2_data),
    .o_load_hazard (load_hazard)
  );

  branch_unit u_bru (
    .i_go        (o_ds_to_es_valid),  // no redirect from a stalled or empty stage
    .i_br_kind   (br_kind),
    .i_br_funct3 (br_funct3),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_pc        (o_pc),
    .i_imm       (o_imm),
    .i_fs_pc     (i_fs_pc),
    .o_br_sel    (o_br_sel),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

// ==== logic/branch_unit.sv ====
// resolves in decode with forwarded operands; redirect only fires while i_go is high
`timescale 1ns/1ps

module branch_unit import rv_isa_pkg::*, id_uop_pkg::*; (
  input  logic             i_go,
  input  br_kind_e         i_br_kind,
  input  logic [F3_WD-1:0] i_br_funct3,
  input  logic [XLEN-1:0]  i_rs1_data,
  input  logic [XLEN-1:0]  i_rs2_data,
  input  logic [XLEN-1:0]  i_pc,
  input  logic [XLEN-1:0]  i_imm,
  input  logic [XLEN-1:0]  i_fs_pc,
  output logic             o_br_sel,
  output logic             o_br_taken,
  output logic [XLEN-1:0]  o_br_target
);

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            cond_hit;
  logic            jump;
  logic [XLEN-1:0] jalr_sum;

  assign eq   = i_rs1_data == i_rs2_data;
  assign lt_s = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign lt_u = i_rs1_data < i_rs2_data;

  always_comb begin
    case (i_br_funct3)
      F3_BEQ:  cond_hit = eq;
      F3_BNE:  cond_hit = ~eq;
      F3_BLT:  cond_hit = lt_s;
      F3_BGE:  cond_hit = ~lt_s;
      F3_BLTU: cond_hit = lt_u;
      F3_BGEU: cond_hit = ~lt_u;
      default: cond_hit = 1'b0;
    endcase
  end

  assign jump     = (i_br_kind == BR_JAL) || (i_br_kind == BR_JALR);
  assign jalr_sum = i_rs1_data + i_imm;

  assign o_br_target = (i_br_kind == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;

  assign o_br_sel = i_go & (jump | ((i_br_kind == BR_COND) & cond_hit));

  // no flush needed when fetch already sits on the target
  assign o_br_taken = o_br_sel & (o_br_target != i_fs_pc);

endmodule

// ==== logic/operand_bypass.sv ====
// an rd of zero means no forward; load data from execute is not ready, so it raises a stall
`timescale 1ns/1ps

module operand_bypass import rv_isa_pkg::*; (
  input  logic [GPR_ADDR_WD-1:0] i_rs1,
  input  logic [GPR_ADDR_WD-1:0] i_rs2,
  input  logic [XLEN-1:0]        i_rf_rdata1,
  input  logic [XLEN-1:0]        i_rf_rdata2,
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [XLEN-1:0]        i_es_result,
  input  logic                   i_es_load_sel,
  input  logic [GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [XLEN-1:0]        i_ms_result,
  input  logic [GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [XLEN-1:0]        i_ws_result,
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data,
  output logic                   o_load_hazard
);

  logic es_hit1, ms_hit1, ws_hit1;
  logic es_hit2, ms_hit2, ws_hit2;

  assign es_hit1 = (i_es_rd != '0) && (i_es_rd == i_rs1);
  assign ms_hit1 = (i_ms_rd != '0) && (i_ms_rd == i_rs1);
  assign ws_hit1 = (i_ws_rd != '0) && (i_ws_rd == i_rs1);
  assign es_hit2 = (i_es_rd != '0) && (i_es_rd == i_rs2);
  assign ms_hit2 = (i_ms_rd != '0) && (i_ms_rd == i_rs2);
  assign ws_hit2 = (i_ws_rd != '0) && (i_ws_rd == i_rs2);

  // youngest producer wins
  assign o_rs1_data = es_hit1 ? i_es_result :
                      ms_hit1 ? i_ms_result :
                      ws_hit1 ? i_ws_result : i_rf_rdata1;

  assign o_rs2_data = es_hit2 ? i_es_result :
                      ms_hit2 ? i_ms_result :
                      ws_hit2 ? i_ws_result : i_rf_rdata2;

  assign o_load_hazard = i_es_load_sel & (es_hit1 | es_hit2);

endmodule

// ==== logic/gpr_file.sv ====
// async reads see the old value during a same-cycle write; the caller bypasses writeback
`timescale 1ns/1ps

module gpr_file import rv_isa_pkg::*; (
  input  logic                   i_clk,
  input  logic [GPR_ADDR_WD-1:0] i_raddr1,
  output logic [XLEN-1:0]        o_rdata1,
  input  logic [GPR_ADDR_WD-1:0] i_raddr2,
  output logic [XLEN-1:0]        o_rdata2,
  input  logic                   i_wen,
  input  logic [GPR_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]        i_wdata
);

  logic [XLEN-1:0] regs [NUM_GPR];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin  // x0 is hardwired
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== logic/inst_decoder.sv ====
// RV64I subset only; funct7/funct6 are checked, unsupported words give o_invalid_inst
`timescale 1ns/1ps

module inst_decoder import rv_isa_pkg::*, id_uop_pkg::*; (
  input  logic [INST_WD-1:0]     i_inst,
  output logic [GPR_ADDR_WD-1:0] o_rs1,
  output logic [GPR_ADDR_WD-1:0] o_rs2,
  output logic [GPR_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]        o_imm,
  output alu_op_e                o_alu_op,
  output src1_sel_e              o_src1_sel,
  output src2_sel_e              o_src2_sel,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output logic                   o_load_sel,
  output br_kind_e               o_br_kind,
  output logic [F3_WD-1:0]       o_br_funct3,
  output logic                   o_invalid_inst
);

  logic [OPC_WD-1:0] opcode;
  logic [F3_WD-1:0]  funct3;
  logic [6:0]        funct7;
  logic [5:0]        funct6;  // rv64 shifts use a 6 bit shamt
  logic [XLEN-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign funct6 = i_inst[31:26];

  assign o_rs1       = i_inst[19:15];
  assign o_rs2       = i_inst[24:20];
  assign o_rd        = i_inst[11:7];
  assign o_br_funct3 = funct3;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // shared funct3 map of op and op-imm
  function automatic alu_op_e f3_to_alu(input logic [F3_WD-1:0] f3);
    case (f3)
      3'b000:  f3_to_alu = ALU_ADD;
      3'b001:  f3_to_alu = ALU_SLL;
      3'b010:  f3_to_alu = ALU_SLT;
      3'b011:  f3_to_alu = ALU_SLTU;
      3'b100:  f3_to_alu = ALU_XOR;
      3'b101:  f3_to_alu = ALU_SRL;
      3'b110:  f3_to_alu = ALU_OR;
      default: f3_to_alu = ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_imm          = '0;
    o_alu_op       = ALU_ADD;
    o_src1_sel     = SRC1_RS1;
    o_src2_sel     = SRC2_RS2;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_load_sel     = 1'b0;
    o_br_kind      = BR_NONE;
    o_invalid_inst = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = ALU_PASS_B;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm      = imm_u;
        o_src1_sel = SRC1_PC;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        o_imm          = (opcode == OPC_JAL) ? imm_j : imm_i;
        o_src1_sel     = SRC1_PC;  // rd = pc + 4
        o_src2_sel     = SRC2_FOUR;
        o_gpr_wen      = 1'b1;
        o_br_kind      = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        o_invalid_inst = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_imm          = imm_b;
        o_br_kind      = BR_COND;
        o_invalid_inst = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OPC_LOAD: begin
        o_imm          = imm_i;
        o_src2_sel     = SRC2_IMM;
        o_gpr_wen      = 1'b1;
        o_mem_ren      = 1'b1;
        o_load_sel     = 1'b1;
        o_invalid_inst = funct3 != F3_LD;
      end
      OPC_STORE: begin
        o_imm          = imm_s;
        o_src2_sel     = SRC2_IMM;
        o_mem_wen      = 1'b1;
        o_invalid_inst = funct3 != F3_SD;
      end
      OPC_OP_IMM: begin
        o_imm      = imm_i;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
        o_alu_op   = f3_to_alu(funct3);
        if (funct3 == 3'b001) begin
          o_invalid_inst = funct6 != 6'b000000;
        end else if (funct3 == 3'b101) begin
          if (funct6 == 6'b010000) begin
            o_alu_op = ALU_SRA;
          end else begin
            o_invalid_inst = funct6 != 6'b000000;
          end
        end
      end
      OPC_OP: begin
        o_gpr_wen = 1'b1;
        if (funct7 == 7'b0000000) begin
          o_alu_op = f3_to_alu(funct3);
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          o_alu_op = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          o_alu_op = ALU_SRA;
        end else begin
          o_invalid_inst = 1'b1;
        end
      end
      default: o_invalid_inst = 1'b1;
    endcase
    // nothing may write or redirect on a bad word
    if (o_invalid_inst) begin
      o_gpr_wen  = 1'b0;
      o_mem_ren  = 1'b0;
      o_mem_wen  = 1'b0;
      o_load_sel = 1'b0;
      o_br_kind  = BR_NONE;
    end
  end

endmodule

// ==== logic/id_pipe_reg.sv ====
// fetch must hold inst/pc stable until o_ds_allowin; stored inst/pc are unknown until first accept
`timescale 1ns/1ps

module id_pipe_reg import rv_isa_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_fs_to_ds_valid,
  input  logic [INST_WD-1:0] i_fs_inst,
  input  logic [XLEN-1:0]    i_fs_pc,
  input  logic               i_es_allowin,
  input  logic               i_load_hazard,
  input  logic               i_br_taken,
  output logic               o_ds_allowin,
  output logic               o_ds_to_es_valid,
  output logic [INST_WD-1:0] o_inst,
  output logic [XLEN-1:0]    o_pc
);

  logic ds_valid;
  logic ds_ready_go;
  logic accept;

  // only stall source is a load still in execute
  assign ds_ready_go = ~i_load_hazard;

  assign o_ds_allowin     = ~ds_valid | (ds_ready_go & i_es_allowin);
  assign o_ds_to_es_valid = ds_valid & ds_ready_go;

  assign accept = i_fs_to_ds_valid & o_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  // wrong-path fetch becomes a nop but keeps its pc
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_inst <= i_br_taken ? INST_NOP : i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

// ==== logic/id_uop_pkg.sv ====
// micro-op codes from decode to execute; execute must decode these same encodings
package id_uop_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B  // result is operand b, used by lui
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1,
    SRC1_PC
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_RS2,
    SRC2_IMM,
    SRC2_FOUR  // link address for jal/jalr
  } src2_sel_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_COND,
    BR_JAL,
    BR_JALR
  } br_kind_e;

endpackage

// ==== logic/rv_isa_pkg.sv ====
// RV64I encodings for the decode subset only; no compressed, CSR or word (W) opcodes
package rv_isa_pkg;

  localparam int XLEN        = 64;  // data and pc width
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int NUM_GPR     = 32;

  localparam int OPC_WD = 7;
  localparam int F3_WD  = 3;

  // major opcodes
  localparam logic [OPC_WD-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPC_WD-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPC_WD-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPC_WD-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [OPC_WD-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPC_WD-1:0] OPC_LOAD   = 7'b0000011;
  localparam logic [OPC_WD-1:0] OPC_STORE  = 7'b0100011;
  localparam logic [OPC_WD-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [OPC_WD-1:0] OPC_OP     = 7'b0110011;

  // branch compares
  localparam logic [F3_WD-1:0] F3_BEQ  = 3'b000;
  localparam logic [F3_WD-1:0] F3_BNE  = 3'b001;
  localparam logic [F3_WD-1:0] F3_BLT  = 3'b100;
  localparam logic [F3_WD-1:0] F3_BGE  = 3'b101;
  localparam logic [F3_WD-1:0] F3_BLTU = 3'b110;
  localparam logic [F3_WD-1:0] F3_BGEU = 3'b111;

  // doubleword memory access only
  localparam logic [F3_WD-1:0] F3_LD = 3'b011;
  localparam logic [F3_WD-1:0] F3_SD = 3'b011;

  localparam logic [INST_WD-1:0] INST_NOP = 32'h0000_0013;  // addi x0,x0,0

endpackage
